/* src.f */
rtl/rob_conf_pkg.sv
rtl/rob_inst_pkg.sv
rtl/onehot_select.sv
rtl/rob_entry.sv
rtl/rob_alloc.sv
rtl/rob_commit.sv
rtl/rob_top.sv
test/rob_tb_clk.sv
test/rob_tb.sv

/* test/rob_tb.sv */
`timescale 1ns/100ps

module rob_tb;

  import rob_conf_pkg::*;
  import rob_inst_pkg::*;

  localparam int TESTS = 5;
  localparam int CYCLE_LIMIT = TESTS * 40 + 10;

  // One dispatched group as the model sees it
  typedef struct packed {
    logic [CMT_ID_W-1:0]               id;
    logic [DISP_SIZE-1:0]              mask;
    logic [DISP_SIZE-1:0]              done;
    logic [DISP_SIZE-1:0]              exc;
    logic [PC_W-1:1]                   pc;
    logic [DISP_SIZE-1:0][CAUSE_W-1:0] cause;
    logic [DISP_SIZE-1:0][TVAL_W-1:0]  tval;
  } grp_t;

  logic                                        i_clk;
  logic                                        i_reset_n;
  logic                                        i_disp_valid;
  logic                                        o_disp_ready;
  logic [CMT_ID_W-1:0]                         o_disp_cmt_id;
  logic [DISP_SIZE-1:0]                        i_disp_grp_id;
  logic [PC_W-1:1]                             i_disp_pc;
  logic [DISP_SIZE-1:0]                        i_disp_except_valid;
  logic [DISP_SIZE-1:0][CAUSE_W-1:0]           i_disp_except_cause;
  logic [CMT_BUS_SIZE-1:0]                     i_done_valid;
  logic [CMT_BUS_SIZE-1:0][CMT_ID_W-1:0]       i_done_cmt_id;
  logic [CMT_BUS_SIZE-1:0][DISP_SIZE-1:0]      i_done_grp_id;
  logic [CMT_BUS_SIZE-1:0]                     i_done_except_valid;
  logic [CMT_BUS_SIZE-1:0][CAUSE_W-1:0]        i_done_except_cause;
  logic [CMT_BUS_SIZE-1:0][TVAL_W-1:0]         i_done_except_tval;
  logic                                        o_cmt_valid;
  logic [CMT_ID_W-1:0]                         o_cmt_cmt_id;
  logic [DISP_SIZE-1:0]                        o_cmt_grp_id;
  logic [PC_W-1:1]                             o_cmt_pc;
  logic                                        o_cmt_except_valid;
  logic [CAUSE_W-1:0]                          o_cmt_except_cause;
  logic [TVAL_W-1:0]                           o_cmt_except_tval;

  grp_t                grp_q [$];
  logic                exp_avail;
  logic                exp_done;
  logic                exp_exc;
  logic [CMT_ID_W-1:0] exp_id;
  logic [CMT_ID_W-1:0] exp_next_id;
  logic [DISP_SIZE-1:0] exp_grp;
  logic [PC_W-1:1]     exp_pc;
  logic [CAUSE_W-1:0]  exp_cause;
  logic [TVAL_W-1:0]   exp_tval;
  logic                exp_ready;
  logic                chk_idle;
  logic                chk_ready;
  logic                lat_fire;
  int                  err_count = 0;
  int                  pass_count = 0;
  int                  fail_count = 0;
  int                  cycles = 0;

  rob_tb_clk u_clk (
    .o_clk     (i_clk),
    .o_reset_n (i_reset_n)
  );

  rob_top i_rob_top (.*);

  task automatic log_mismatch(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
    $display("FAIL %s expected 0x%0h actual 0x%0h", name, expected, actual);
    err_count++;
  endtask

  task automatic note_failure(input string what);
    $display("Check failed: %s", what);
    err_count++;
  endtask

  // Lowest excepting lane of the oldest group sets the expected cause and tval
  task automatic update_expect();
    grp_t g;
    g = '0;
    if (grp_q.size() > 0) begin
      g = grp_q[0];
    end
    exp_avail = (grp_q.size() > 0);
    exp_id = g.id;
    exp_grp = g.mask;
    exp_pc = g.pc;
    exp_done = (g.done == g.mask);
    exp_exc = |g.exc;
    exp_cause = '0;
    exp_tval = '0;
    for (int d = DISP_SIZE - 1; d >= 0; d--) begin
      if (g.exc[d]) begin
        exp_cause = g.cause[d];
        exp_tval = g.tval[d];
      end
    end
  endtask

  // Reference model retires before it records a same-edge dispatch
  always @(posedge i_clk) begin : model
    grp_t g;
    if (!i_reset_n) begin
      exp_next_id = '0;
    end else begin
      if (o_cmt_valid && grp_q.size() > 0) begin
        if (exp_exc) begin
          grp_q.delete();  // Everything younger is dead
        end else begin
          void'(grp_q.pop_front());
        end
      end
      if (i_disp_valid && o_disp_ready) begin
        g = '0;
        g.id = exp_next_id;
        g.mask = i_disp_grp_id;
        g.done = i_disp_except_valid & i_disp_grp_id;
        g.exc = g.done;
        g.pc = i_disp_pc;
        g.cause = i_disp_except_cause;
        for (int d = 0; d < DISP_SIZE; d++) begin
          g.tval[d] = TVAL_W'({i_disp_pc, 1'b0});
        end
        grp_q.push_back(g);
        exp_next_id = exp_next_id + 1'b1;
      end
    end
    update_expect();  // Reports of this edge count from the next edge on
    if (i_reset_n) begin
      for (int c = 0; c < CMT_BUS_SIZE; c++) begin
        for (int i = 0; i < grp_q.size(); i++) begin
          if (i_done_valid[c] && grp_q[i].id == i_done_cmt_id[c]) begin
            g = grp_q[i];
            g.done = g.done | i_done_grp_id[c];
            for (int d = 0; d < DISP_SIZE; d++) begin
              if (i_done_grp_id[c][d] && i_done_except_valid[c]) begin
                g.exc[d] = 1'b1;
                g.cause[d] = i_done_except_cause[c];
                g.tval[d] = i_done_except_tval[c];
              end
            end
            grp_q[i] = g;
          end
        end
      end
    end
  end

  a_idle_valid: assert property (@(posedge i_clk) chk_idle |-> !o_cmt_valid)
    else log_mismatch("o_cmt_valid", 0, $sampled(o_cmt_valid));
  a_idle_exc: assert property (@(posedge i_clk) chk_idle |-> !o_cmt_except_valid)
    else log_mismatch("o_cmt_except_valid", 0, $sampled(o_cmt_except_valid));
  a_ready: assert property (@(posedge i_clk) chk_ready |-> o_disp_ready == exp_ready)
    else log_mismatch("o_disp_ready", $sampled(exp_ready), $sampled(o_disp_ready));
  a_disp_id: assert property (@(posedge i_clk) disable iff (!i_reset_n)
      i_disp_valid && o_disp_ready |-> o_disp_cmt_id == exp_next_id)
    else log_mismatch("o_disp_cmt_id", $sampled(exp_next_id), $sampled(o_disp_cmt_id));
  a_cmt_done: assert property (@(posedge i_clk) disable iff (!i_reset_n)
      o_cmt_valid |-> exp_avail && exp_done)
    else note_failure("a commit came with no fully reported group waiting");
  a_exc_alone: assert property (@(posedge i_clk) disable iff (!i_reset_n)
      o_cmt_except_valid |-> o_cmt_valid)
    else note_failure("an exception was reported without a commit");
  a_cmt_id: assert property (@(posedge i_clk) disable iff (!i_reset_n)
      o_cmt_valid |-> o_cmt_cmt_id == exp_id)
    else log_mismatch("o_cmt_cmt_id", $sampled(exp_id), $sampled(o_cmt_cmt_id));
  a_cmt_grp: assert property (@(posedge i_clk) disable iff (!i_reset_n)
      o_cmt_valid |-> o_cmt_grp_id == exp_grp)
    else log_mismatch("o_cmt_grp_id", $sampled(exp_grp), $sampled(o_cmt_grp_id));
  a_cmt_pc: assert property (@(posedge i_clk) disable iff (!i_reset_n)
      o_cmt_valid |-> o_cmt_pc == exp_pc)
    else log_mismatch("o_cmt_pc", $sampled(exp_pc), $sampled(o_cmt_pc));
  a_cmt_exc: assert property (@(posedge i_clk) disable iff (!i_reset_n)
      o_cmt_valid |-> o_cmt_except_valid == exp_exc)
    else log_mismatch("o_cmt_except_valid", $sampled(exp_exc),
                      $sampled(o_cmt_except_valid));
  a_cmt_cause: assert property (@(posedge i_clk) disable iff (!i_reset_n)
      o_cmt_valid && exp_exc |-> o_cmt_except_cause == exp_cause)
    else log_mismatch("o_cmt_except_cause", $sampled(exp_cause),
                      $sampled(o_cmt_except_cause));
  a_cmt_tval: assert property (@(posedge i_clk) disable iff (!i_reset_n)
      o_cmt_valid && exp_exc |-> o_cmt_except_tval == exp_tval)
    else log_mismatch("o_cmt_except_tval", $sampled(exp_tval),
                      $sampled(o_cmt_except_tval));
  a_latency: assert property (@(posedge i_clk) disable iff (!i_reset_n)
      $past(lat_fire, 2) |-> o_cmt_valid)
    else note_failure("pre-excepted group did not commit two cycles after dispatch");

  always @(posedge i_clk) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Run timed out after %0d cycles before the tests finished", cycles);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  function automatic logic [DISP_SIZE-1:0] random_mask();
    return DISP_SIZE'($urandom_range(1, (1 << DISP_SIZE) - 1));
  endfunction

  task automatic dispatch_group(input logic [DISP_SIZE-1:0] mask,
                                input logic [DISP_SIZE-1:0] exc, input logic lat,
                                output logic [CMT_ID_W-1:0] id);
    while (!o_disp_ready) begin
      @(posedge i_clk);
      #1;
    end
    i_disp_valid = 1'b1;
    i_disp_grp_id = mask;
    i_disp_pc = (PC_W - 1)'($urandom);
    i_disp_except_valid = exc;
    for (int d = 0; d < DISP_SIZE; d++) begin
      i_disp_except_cause[d] = $urandom_range(0, 1) ? CAUSE_INST_PAGE_FAULT : CAUSE_ILLEGAL_INST;
    end
    lat_fire = lat;
    id = o_disp_cmt_id;
    @(posedge i_clk);
    #1;
    i_disp_valid = 1'b0;
    i_disp_except_valid = '0;
    lat_fire = 1'b0;
  endtask

  task automatic drive_report(input int bus, input logic [CMT_ID_W-1:0] id, input int lane,
                              input logic exc);
    i_done_valid[bus] = 1'b1;
    i_done_cmt_id[bus] = id;
    i_done_grp_id[bus] = DISP_SIZE'(1) << lane;
    i_done_except_valid[bus] = exc;
    i_done_except_cause[bus] = $urandom_range(0, 1) ? CAUSE_LOAD_PAGE_FAULT
                                                    : CAUSE_STORE_PAGE_FAULT;
    i_done_except_tval[bus] = $urandom;
  endtask

  task automatic pulse_reports();
    @(posedge i_clk);
    #1;
    i_done_valid = '0;
    i_done_except_valid = '0;
  endtask

  // Two lanes and two buses, so lane d rides bus d or its twin
  task automatic send_all_lanes(input logic [CMT_ID_W-1:0] id,
                                input logic [DISP_SIZE-1:0] mask, input int exc_lane);
    int swap;
    swap = $urandom_range(0, 1);
    for (int d = 0; d < DISP_SIZE; d++) begin
      if (mask[d]) begin
        drive_report(d ^ swap, id, d, d == exc_lane);
      end
    end
    pulse_reports();
  endtask

  task automatic wait_drained(input int left);
    while (grp_q.size() > left) begin
      @(posedge i_clk);
      #1;
    end
  endtask

  task automatic end_test(input int num, input string name, input int errs_before);
    if (err_count == errs_before) begin
      pass_count++;
      $display("Test %0d %s: pass", num, name);
    end else begin
      fail_count++;
      $display("Test %0d %s: fail with %0d errors", num, name, err_count - errs_before);
    end
  endtask

  initial begin
    logic [CMT_ID_W-1:0]  ids [5];
    logic [DISP_SIZE-1:0] masks [5];
    int                   pend_q [$];
    int                   k;
    int                   el;
    int                   errs_before;
    void'($urandom(56801));
    i_disp_valid = 1'b0;
    i_disp_grp_id = '0;
    i_disp_pc = '0;
    i_disp_except_valid = '0;
    i_disp_except_cause = '0;
    i_done_valid = '0;
    i_done_cmt_id = '0;
    i_done_grp_id = '0;
    i_done_except_valid = '0;
    i_done_except_cause = '0;
    i_done_except_tval = '0;
    chk_idle = 1'b0;
    chk_ready = 1'b0;
    exp_ready = 1'b1;
    lat_fire = 1'b0;
    wait (i_reset_n);
    @(posedge i_clk);
    #1;

    errs_before = err_count;
    chk_idle = 1'b1;
    chk_ready = 1'b1;
    repeat (2) begin
      @(posedge i_clk);
      #1;
    end
    chk_idle = 1'b0;
    chk_ready = 1'b0;
    end_test(1, "reset state", errs_before);

    errs_before = err_count;
    for (int i = 0; i < 3; i++) begin
      masks[i] = random_mask();
      dispatch_group(masks[i], '0, 1'b0, ids[i]);
      for (int d = 0; d < DISP_SIZE; d++) begin
        if (masks[i][d]) begin
          pend_q.push_back(ids[i] * DISP_SIZE + d);
        end
      end
    end
    while (pend_q.size() > 0) begin  // Random order, random bus, random gaps
      for (int c = 0; c < CMT_BUS_SIZE; c++) begin
        if (pend_q.size() > 0 && $urandom_range(0, 3) != 0) begin
          k = $urandom_range(0, pend_q.size() - 1);
          drive_report(c, CMT_ID_W'(pend_q[k] / DISP_SIZE), pend_q[k] % DISP_SIZE, 1'b0);
          pend_q.delete(k);
        end
      end
      pulse_reports();
    end
    wait_drained(0);
    end_test(2, "out of order reports", errs_before);

    errs_before = err_count;
    dispatch_group('1, '1, 1'b1, ids[0]);
    wait_drained(0);
    dispatch_group('1, DISP_SIZE'(2), 1'b0, ids[1]);  // Lane 1 faults, lane 0 executes
    send_all_lanes(ids[1], DISP_SIZE'(1), -1);
    wait_drained(0);
    end_test(3, "dispatch exceptions", errs_before);

    errs_before = err_count;
    for (int i = 0; i < 3; i++) begin
      masks[i] = random_mask();
      dispatch_group(masks[i], '0, 1'b0, ids[i]);
    end
    send_all_lanes(ids[2], masks[2], -1);
    send_all_lanes(ids[1], masks[1], -1);
    do begin
      el = $urandom_range(0, DISP_SIZE - 1);
    end while (!masks[0][el]);
    send_all_lanes(ids[0], masks[0], el);
    wait_drained(0);
    masks[3] = random_mask();
    dispatch_group(masks[3], '0, 1'b0, ids[3]);
    send_all_lanes(ids[3], masks[3], -1);
    wait_drained(0);
    end_test(4, "report exception and flush", errs_before);

    errs_before = err_count;
    for (int i = 0; i < ROB_ENTRIES; i++) begin
      masks[i] = random_mask();
      dispatch_group(masks[i], '0, 1'b0, ids[i]);
    end
    exp_ready = 1'b0;
    chk_ready = 1'b1;
    @(posedge i_clk);
    #1;
    chk_ready = 1'b0;
    send_all_lanes(ids[0], masks[0], -1);
    wait_drained(ROB_ENTRIES - 1);
    exp_ready = 1'b1;
    chk_ready = 1'b1;
    @(posedge i_clk);
    #1;
    chk_ready = 1'b0;
    masks[4] = random_mask();
    dispatch_group(masks[4], '0, 1'b0, ids[4]);
    for (int i = 1; i < 5; i++) begin
      send_all_lanes(ids[i], masks[i], -1);
    end
    wait_drained(0);
    end_test(5, "full and wrap", errs_before);

    $display("Tests passed %0d failed %0d, check errors %0d", pass_count, fail_count,
             err_count);
    if (fail_count == 0 && err_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

/* test/rob_tb_clk.sv */
`timescale 1ns/100ps

module rob_tb_clk (
  output logic o_clk,
  output logic o_reset_n
);

  initial begin
    o_clk = 1'b0;
    forever #4 o_clk = ~o_clk;  // 8 ns period
  end

  initial begin
    o_reset_n = 1'b0;
    repeat (10) @(posedge o_clk);
    #1 o_reset_n = 1'b1;
  end

endmodule

/* rtl/rob_top.sv */
`timescale 1ns/100ps

module rob_top (
  input  logic                                  i_clk,
  input  logic                                  i_reset_n,

  input  logic                                  i_disp_valid,
  output logic                                  o_disp_ready,
  output logic [rob_conf_pkg::CMT_ID_W-1:0]     o_disp_cmt_id,
  input  logic [rob_conf_pkg::DISP_SIZE-1:0]    i_disp_grp_id,
  input  logic [rob_inst_pkg::PC_W-1:1]         i_disp_pc,
  input  logic [rob_conf_pkg::DISP_SIZE-1:0]    i_disp_except_valid,
  input  logic [rob_conf_pkg::DISP_SIZE-1:0][rob_inst_pkg::CAUSE_W-1:0] i_disp_except_cause,

  input  logic [rob_conf_pkg::CMT_BUS_SIZE-1:0] i_done_valid,
  input  logic [rob_conf_pkg::CMT_BUS_SIZE-1:0][rob_conf_pkg::CMT_ID_W-1:0] i_done_cmt_id,
  input  logic [rob_conf_pkg::CMT_BUS_SIZE-1:0][rob_conf_pkg::DISP_SIZE-1:0] i_done_grp_id,
  input  logic [rob_conf_pkg::CMT_BUS_SIZE-1:0] i_done_except_valid,
  input  logic [rob_conf_pkg::CMT_BUS_SIZE-1:0][rob_inst_pkg::CAUSE_W-1:0] i_done_except_cause,
  input  logic [rob_conf_pkg::CMT_BUS_SIZE-1:0][rob_inst_pkg::TVAL_W-1:0] i_done_except_tval,

  output logic                                  o_cmt_valid,
  output logic [rob_conf_pkg::CMT_ID_W-1:0]     o_cmt_cmt_id,
  output logic [rob_conf_pkg::DISP_SIZE-1:0]    o_cmt_grp_id,
  output logic [rob_inst_pkg::PC_W-1:1]         o_cmt_pc,
  output logic                                  o_cmt_except_valid,
  output logic [rob_inst_pkg::CAUSE_W-1:0]      o_cmt_except_cause,
  output logic [rob_inst_pkg::TVAL_W-1:0]       o_cmt_except_tval
);

  import rob_conf_pkg::*;
  import rob_inst_pkg::*;

  logic [ROB_ENTRIES-1:0]                                w_load_valid;
  logic [ROB_ENTRIES-1:0]                                w_valid;
  logic [ROB_ENTRIES-1:0]                                w_dead;
  logic [ROB_ENTRIES-1:0]                                w_all_done;
  logic [ROB_ENTRIES-1:0][DISP_SIZE-1:0]                 w_grp_id;
  logic [ROB_ENTRIES-1:0][PC_W-1:1]                      w_pc;
  logic [ROB_ENTRIES-1:0][DISP_SIZE-1:0]                 w_except_valid;
  logic [ROB_ENTRIES-1:0][DISP_SIZE-1:0][EXC_INFO_W-1:0] w_except_info;
  logic [ROB_ENTRIES-1:0]                                w_commit_finish;
  logic                                                  w_kill;
  logic                                                  w_finish;

  rob_alloc u_rob_alloc (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_disp_valid  (i_disp_valid),
    .o_disp_ready  (o_disp_ready),
    .o_disp_cmt_id (o_disp_cmt_id),
    .i_finish      (w_finish),
    .o_load_valid  (w_load_valid)
  );

  for (genvar e = 0; e < ROB_ENTRIES; e++) begin : g_entry
    rob_entry u_rob_entry (
      .i_clk               (i_clk),
      .i_reset_n           (i_reset_n),
      .i_entry_idx         (ROB_IDX_W'(e)),
      .i_load_valid        (w_load_valid[e]),
      .i_load_grp_id       (i_disp_grp_id),
      .i_load_pc           (i_disp_pc),
      .i_load_except_valid (i_disp_except_valid),
      .i_load_except_cause (i_disp_except_cause),
      .i_done_valid        (i_done_valid),
      .i_done_cmt_id       (i_done_cmt_id),
      .i_done_grp_id       (i_done_grp_id),
      .i_done_except_valid (i_done_except_valid),
      .i_done_except_cause (i_done_except_cause),
      .i_done_except_tval  (i_done_except_tval),
      .i_kill              (w_kill),
      .i_commit_finish     (w_commit_finish[e]),
      .o_valid             (w_valid[e]),
      .o_dead              (w_dead[e]),
      .o_all_done          (w_all_done[e]),
      .o_grp_id            (w_grp_id[e]),
      .o_pc                (w_pc[e]),
      .o_except_valid      (w_except_valid[e]),
      .o_except_info       (w_except_info[e])
    );
  end

  rob_commit u_rob_commit (
    .i_clk              (i_clk),
    .i_reset_n          (i_reset_n),
    .i_valid            (w_valid),
    .i_dead             (w_dead),
    .i_all_done         (w_all_done),
    .i_grp_id           (w_grp_id),
    .i_pc               (w_pc),
    .i_except_valid     (w_except_valid),
    .i_except_info      (w_except_info),
    .o_commit_finish    (w_commit_finish),
    .o_kill             (w_kill),
    .o_finish           (w_finish),
    .o_cmt_valid        (o_cmt_valid),
    .o_cmt_cmt_id       (o_cmt_cmt_id),
    .o_cmt_grp_id       (o_cmt_grp_id),
    .o_cmt_pc           (o_cmt_pc),
    .o_cmt_except_valid (o_cmt_except_valid),
    .o_cmt_except_cause (o_cmt_except_cause),
    .o_cmt_except_tval  (o_cmt_except_tval)
  );

endmodule

/* rtl/rob_commit.sv */
`timescale 1ns/100ps

module rob_commit (
  input  logic                                 i_clk,
  input  logic                                 i_reset_n,

  input  logic [rob_conf_pkg::ROB_ENTRIES-1:0] i_valid,
  input  logic [rob_conf_pkg::ROB_ENTRIES-1:0] i_dead,
  input  logic [rob_conf_pkg::ROB_ENTRIES-1:0] i_all_done,
  input  logic [rob_conf_pkg::ROB_ENTRIES-1:0][rob_conf_pkg::DISP_SIZE-1:0] i_grp_id,
  input  logic [rob_conf_pkg::ROB_ENTRIES-1:0][rob_inst_pkg::PC_W-1:1] i_pc,
  input  logic [rob_conf_pkg::ROB_ENTRIES-1:0][rob_conf_pkg::DISP_SIZE-1:0] i_except_valid,
  input  logic [rob_conf_pkg::ROB_ENTRIES-1:0][rob_conf_pkg::DISP_SIZE-1:0]
               [rob_inst_pkg::EXC_INFO_W-1:0] i_except_info,

  output logic [rob_conf_pkg::ROB_ENTRIES-1:0] o_commit_finish,
  output logic                                 o_kill,
  output logic                                 o_finish,

  output logic                                 o_cmt_valid,
  output logic [rob_conf_pkg::CMT_ID_W-1:0]    o_cmt_cmt_id,
  output logic [rob_conf_pkg::DISP_SIZE-1:0]   o_cmt_grp_id,
  output logic [rob_inst_pkg::PC_W-1:1]        o_cmt_pc,
  output logic                                 o_cmt_except_valid,
  output logic [rob_inst_pkg::CAUSE_W-1:0]     o_cmt_except_cause,
  output logic [rob_inst_pkg::TVAL_W-1:0]      o_cmt_except_tval
);

  import rob_conf_pkg::*;
  import rob_inst_pkg::*;

  typedef logic [EXC_INFO_W:0] lane_exc_t;  // {valid, cause, tval}

  logic [CMT_ID_W-1:0]  r_head;
  logic [ROB_IDX_W-1:0] w_head_idx;
  logic                 w_head_dead;
  logic                 w_finish;
  logic [DISP_SIZE-1:0] w_head_exc;
  logic [DISP_SIZE-1:0] w_exc_oh;
  lane_exc_t            w_lane_exc [DISP_SIZE];
  lane_exc_t            w_sel_exc;

  assign w_head_idx = r_head[ROB_IDX_W-1:0];
  assign w_head_dead = i_dead[w_head_idx];
  assign w_finish = i_valid[w_head_idx] & (i_all_done[w_head_idx] | w_head_dead);

  // Lowest excepting lane wins
  assign w_head_exc = i_except_valid[w_head_idx];
  assign w_exc_oh = w_head_exc & (~w_head_exc + 1'b1);

  for (genvar d = 0; d < DISP_SIZE; d++) begin : g_lane
    assign w_lane_exc[d] = {w_head_exc[d], i_except_info[w_head_idx][d]};
  end

  onehot_select #(
    .T     (lane_exc_t),
    .WORDS (DISP_SIZE)
  ) u_exc_sel (
    .i_oh       (w_exc_oh),
    .i_data     (w_lane_exc),
    .o_selected (w_sel_exc)
  );

  assign o_finish = w_finish;
  assign o_commit_finish = w_finish ? (ROB_ENTRIES'(1) << w_head_idx) : '0;
  assign o_kill = w_finish & ~w_head_dead & w_sel_exc[EXC_INFO_W];  // Flush everything in flight

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_head <= '0;
      o_cmt_valid <= 1'b0;
      o_cmt_except_valid <= 1'b0;
    end else begin
      if (w_finish) begin
        r_head <= r_head + 1'b1;
      end
      o_cmt_valid <= w_finish & ~w_head_dead;  // Dead groups drain silently
      o_cmt_except_valid <= o_kill;
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_finish) begin
      o_cmt_cmt_id <= r_head;
      o_cmt_grp_id <= i_grp_id[w_head_idx];
      o_cmt_pc <= i_pc[w_head_idx];
      {o_cmt_except_cause, o_cmt_except_tval} <= w_sel_exc[EXC_INFO_W-1:0];
    end
  end

endmodule

/* rtl/rob_alloc.sv */
`timescale 1ns/100ps

module rob_alloc (
  input  logic                                 i_clk,
  input  logic                                 i_reset_n,
  input  logic                                 i_disp_valid,
  output logic                                 o_disp_ready,
  output logic [rob_conf_pkg::CMT_ID_W-1:0]    o_disp_cmt_id,
  input  logic                                 i_finish,
  output logic [rob_conf_pkg::ROB_ENTRIES-1:0] o_load_valid
);

  import rob_conf_pkg::*;

  logic [CMT_ID_W-1:0] r_tail;
  logic [CNT_W-1:0]    r_count;
  logic                w_disp_fire;

  assign o_disp_ready = (r_count < CNT_W'(ROB_ENTRIES));
  assign w_disp_fire = i_disp_valid & o_disp_ready;
  assign o_disp_cmt_id = r_tail;

  // One load strobe to the slot under the tail
  assign o_load_valid = w_disp_fire ? (ROB_ENTRIES'(1) << r_tail[ROB_IDX_W-1:0]) : '0;

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_tail <= '0;
    end else if (w_disp_fire) begin
      r_tail <= r_tail + 1'b1;  // Wrap bit toggles on its own
    end
  end

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_count <= '0;
    end else begin
      case ({w_disp_fire, i_finish})
        2'b10: r_count <= r_count + 1'b1;
        2'b01: r_count <= r_count - 1'b1;
        default: r_count <= r_count;  // Both or neither
      endcase
    end
  end

endmodule

/* rtl/rob_entry.sv */
`timescale 1ns/100ps

module rob_entry (
  input  logic                                  i_clk,
  input  logic                                  i_reset_n,
  input  logic [rob_conf_pkg::ROB_IDX_W-1:0]    i_entry_idx,

  input  logic                                  i_load_valid,
  input  logic [rob_conf_pkg::DISP_SIZE-1:0]    i_load_grp_id,
  input  logic [rob_inst_pkg::PC_W-1:1]         i_load_pc,
  input  logic [rob_conf_pkg::DISP_SIZE-1:0]    i_load_except_valid,
  input  logic [rob_conf_pkg::DISP_SIZE-1:0][rob_inst_pkg::CAUSE_W-1:0] i_load_except_cause,

  input  logic [rob_conf_pkg::CMT_BUS_SIZE-1:0] i_done_valid,
  input  logic [rob_conf_pkg::CMT_BUS_SIZE-1:0][rob_conf_pkg::CMT_ID_W-1:0] i_done_cmt_id,
  input  logic [rob_conf_pkg::CMT_BUS_SIZE-1:0][rob_conf_pkg::DISP_SIZE-1:0] i_done_grp_id,
  input  logic [rob_conf_pkg::CMT_BUS_SIZE-1:0] i_done_except_valid,
  input  logic [rob_conf_pkg::CMT_BUS_SIZE-1:0][rob_inst_pkg::CAUSE_W-1:0] i_done_except_cause,
  input  logic [rob_conf_pkg::CMT_BUS_SIZE-1:0][rob_inst_pkg::TVAL_W-1:0] i_done_except_tval,

  input  logic                                  i_kill,
  input  logic                                  i_commit_finish,

  output logic                                  o_valid,
  output logic                                  o_dead,
  output logic                                  o_all_done,
  output logic [rob_conf_pkg::DISP_SIZE-1:0]    o_grp_id,
  output logic [rob_inst_pkg::PC_W-1:1]         o_pc,
  output logic [rob_conf_pkg::DISP_SIZE-1:0]    o_except_valid,
  output logic [rob_conf_pkg::DISP_SIZE-1:0][rob_inst_pkg::EXC_INFO_W-1:0] o_except_info
);

  import rob_conf_pkg::*;
  import rob_inst_pkg::*;

  typedef logic [EXC_INFO_W-1:0] exc_info_t;

  logic                                 r_valid;
  logic                                 r_dead;
  logic [DISP_SIZE-1:0]                 r_grp_id;
  logic [DISP_SIZE-1:0]                 r_done;
  logic [PC_W-1:1]                      r_pc;
  logic [DISP_SIZE-1:0]                 r_except_valid;
  logic [DISP_SIZE-1:0][EXC_INFO_W-1:0] r_except_info;

  exc_info_t                            w_bus_info [CMT_BUS_SIZE];
  logic [DISP_SIZE-1:0]                 w_rpt_hit;
  logic [DISP_SIZE-1:0]                 w_rpt_except;
  logic [DISP_SIZE-1:0][EXC_INFO_W-1:0] w_rpt_info;
  logic [TVAL_W-1:0]                    w_load_tval;

  assign w_load_tval = TVAL_W'({i_load_pc, 1'b0});  // Pre-execution faults trap on the PC

  for (genvar c = 0; c < CMT_BUS_SIZE; c++) begin : g_bus
    assign w_bus_info[c] = {i_done_except_cause[c], i_done_except_tval[c]};
  end

  for (genvar d = 0; d < DISP_SIZE; d++) begin : g_lane
    logic [CMT_BUS_SIZE-1:0] w_hit;

    for (genvar c = 0; c < CMT_BUS_SIZE; c++) begin : g_match
      assign w_hit[c] = i_done_valid[c] &
                        (i_done_cmt_id[c][ROB_IDX_W-1:0] == i_entry_idx) &
                        (i_done_grp_id[c] == (DISP_SIZE'(1) << d));
    end

    onehot_select #(
      .T     (exc_info_t),
      .WORDS (CMT_BUS_SIZE)
    ) u_rpt_sel (
      .i_oh       (w_hit),
      .i_data     (w_bus_info),
      .o_selected (w_rpt_info[d])
    );

    assign w_rpt_hit[d] = |w_hit;
    assign w_rpt_except[d] = |(w_hit & i_done_except_valid);
  end

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid <= 1'b0;
      r_dead <= 1'b0;
      r_done <= '0;
      r_except_valid <= '0;
    end else if (i_load_valid) begin
      r_valid <= 1'b1;
      r_dead <= i_kill;  // Loaded during a flush
      r_done <= i_load_except_valid & i_load_grp_id;
      r_except_valid <= i_load_except_valid & i_load_grp_id;
    end else if (r_valid) begin
      if (i_commit_finish) begin
        r_valid <= 1'b0;
      end else begin
        r_done <= r_done | w_rpt_hit;
        r_except_valid <= (r_except_valid & ~w_rpt_hit) | (w_rpt_except & w_rpt_hit);
      end
      r_dead <= r_dead | i_kill;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_load_valid) begin
      r_grp_id <= i_load_grp_id;
      r_pc <= i_load_pc;
      for (int d = 0; d < DISP_SIZE; d++) begin
        r_except_info[d] <= {i_load_except_cause[d], w_load_tval};
      end
    end else if (r_valid && !i_commit_finish) begin
      for (int d = 0; d < DISP_SIZE; d++) begin
        if (w_rpt_hit[d]) begin
          r_except_info[d] <= w_rpt_info[d];
        end
      end
    end
  end

  assign o_valid = r_valid;
  assign o_dead = r_dead;
  assign o_all_done = r_valid & (r_grp_id == r_done);
  assign o_grp_id = r_grp_id;
  assign o_pc = r_pc;
  assign o_except_valid = r_except_valid;
  assign o_except_info = r_except_info;

endmodule

/* rtl/onehot_select.sv */
`timescale 1ns/100ps

module onehot_select #(
  parameter type T = logic [31:0],
  parameter int WORDS = 2
) (
  input  logic [WORDS-1:0] i_oh,
  input  T                 i_data [WORDS],
  output T                 o_selected
);

  // Plain OR mux, zero when nothing is selected
  always_comb begin
    o_selected = '0;
    for (int w = 0; w < WORDS; w++) begin
      if (i_oh[w]) begin
        o_selected = o_selected | i_data[w];
      end
    end
  end

endmodule

/* rtl/rob_inst_pkg.sv */
package rob_inst_pkg;

  localparam int PC_W = 32;   // Stored without bit 0
  localparam int TVAL_W = 32;
  localparam int CAUSE_W = 4;

  // Exception cause codes
  localparam logic [CAUSE_W-1:0] CAUSE_ILLEGAL_INST = 4'd2;
  localparam logic [CAUSE_W-1:0] CAUSE_INST_PAGE_FAULT = 4'd12;
  localparam logic [CAUSE_W-1:0] CAUSE_LOAD_PAGE_FAULT = 4'd13;
  localparam logic [CAUSE_W-1:0] CAUSE_STORE_PAGE_FAULT = 4'd15;

  // Cause in the upper bits, trap value below
  localparam int EXC_INFO_W = CAUSE_W + TVAL_W;

endpackage

/* rtl/rob_conf_pkg.sv */
package rob_conf_pkg;

  // Dispatch group shape
  localparam int DISP_SIZE = 2;      // Lanes per group
  localparam int CMT_BUS_SIZE = 2;   // Completion report buses

  // ROB sizing
  localparam int ROB_ENTRIES = 4;
  localparam int ROB_IDX_W = $clog2(ROB_ENTRIES);

  // Commit id carries one extra wrap bit above the entry index
  localparam int CMT_ID_W = ROB_IDX_W + 1;

  // Occupancy counter has to reach ROB_ENTRIES itself
  localparam int CNT_W = $clog2(ROB_ENTRIES + 1);

endpackage
